//--- design/rv_alu_pkg.sv
// ============================================================
// shared widths, RV64I ALU encodings and the instruction union
// imported by every RTL file of the integer ALU core
// ============================================================
package rv_alu_pkg;

  localparam int XLEN    = 64;
  localparam int REG_AW  = 5;
  localparam int INSTR_W = 32;
  localparam int SHAMT_W = 6;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // selects SUB and SRA
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // one instruction word, seen as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } instr_u;

endpackage

//--- design/operand_if.sv
// ============================================================
// decoded operation from decode to execute, one strobe per op
// ============================================================
interface operand_if
  import rv_alu_pkg::*;
();

  logic                valid;
  logic [ALU_OP_W-1:0] alu_op;
  logic [XLEN-1:0]     op_a;
  logic [XLEN-1:0]     op_b;
  logic [REG_AW-1:0]   rd;

  modport src (
    output valid, alu_op, op_a, op_b, rd
  );

  modport dst (
    input valid, alu_op, op_a, op_b, rd
  );

endinterface

//--- design/reg_file.sv
// ============================================================
// integer register file, two combinational reads, one write
// x0 is not stored and always reads as zero
// ============================================================
module reg_file
  import rv_alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] i_rs1_addr,
  input  logic [REG_AW-1:0] i_rs2_addr,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data,
  input  logic              i_wr_valid,
  input  logic [REG_AW-1:0] i_wr_rd,
  input  logic [XLEN-1:0]   i_wr_data
);

  logic [XLEN-1:0] regs [1:2**REG_AW-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 1; k < 2**REG_AW; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr_valid && i_wr_rd != '0) begin
      regs[i_wr_rd] <= i_wr_data;
    end
  end

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- design/decode_stage.sv
// ============================================================
// decode stage, maps the instruction to an ALU op, picks the
// operands with forwarding and registers the bundle for execute
// ============================================================
module decode_stage
  import rv_alu_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_instr_valid,
  input  logic [INSTR_W-1:0] i_instr,
  output logic [REG_AW-1:0]  o_rs1_addr,
  output logic [REG_AW-1:0]  o_rs2_addr,
  input  logic [XLEN-1:0]    i_rs1_data,
  input  logic [XLEN-1:0]    i_rs2_data,
  input  logic               i_ex_valid,
  input  logic [REG_AW-1:0]  i_ex_rd,
  input  logic [XLEN-1:0]    i_ex_data,
  input  logic               i_wb_valid,
  input  logic [REG_AW-1:0]  i_wb_rd,
  input  logic [XLEN-1:0]    i_wb_data,
  operand_if.src             op
);

  instr_u              instr;
  logic                is_reg;
  logic                is_imm;
  logic                alt;
  logic [ALU_OP_W-1:0] alu_op_d;
  logic [XLEN-1:0]     imm_ext;
  logic [XLEN-1:0]     rs1_val;
  logic [XLEN-1:0]     rs2_val;
  logic                valid_d;

  assign instr  = i_instr;
  assign is_reg = (instr.r.opcode == OPC_OP);
  assign is_imm = (instr.i.opcode == OPC_OP_IMM);

  assign o_rs1_addr = instr.r.rs1;
  assign o_rs2_addr = instr.r.rs2;

  // SRAI keeps its alt bit in funct6, above the 6-bit shamt
  assign alt = is_reg ? (instr.r.funct7 == F7_ALT)
                      : (instr.i.imm12[11:6] == F7_ALT[6:1]);

  always_comb begin
    unique case (instr.r.funct3)
      F3_ADD:  alu_op_d = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_op_d = ALU_SLL;
      F3_SLT:  alu_op_d = ALU_SLT;
      F3_SLTU: alu_op_d = ALU_SLTU;
      F3_XOR:  alu_op_d = ALU_XOR;
      F3_SR:   alu_op_d = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_op_d = ALU_OR;
      default: alu_op_d = ALU_AND;
    endcase
  end

  // shift immediates carry only the shamt
  always_comb begin
    if (instr.i.funct3 == F3_SLL || instr.i.funct3 == F3_SR) begin
      imm_ext = {{(XLEN-SHAMT_W){1'b0}}, instr.i.imm12[SHAMT_W-1:0]};
    end else begin
      imm_ext = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    end
  end

  // execute result is newer than write-back, which is newer than the file
  always_comb begin
    if (i_ex_valid && i_ex_rd == instr.r.rs1) begin
      rs1_val = i_ex_data;
    end else if (i_wb_valid && i_wb_rd == instr.r.rs1) begin
      rs1_val = i_wb_data;
    end else begin
      rs1_val = i_rs1_data;
    end
    if (i_ex_valid && i_ex_rd == instr.r.rs2) begin
      rs2_val = i_ex_data;
    end else if (i_wb_valid && i_wb_rd == instr.r.rs2) begin
      rs2_val = i_wb_data;
    end else begin
      rs2_val = i_rs2_data;
    end
  end

  assign valid_d = i_instr_valid && (is_reg || is_imm) && (instr.r.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    op.alu_op <= alu_op_d;
    op.op_a   <= rs1_val;
    op.op_b   <= is_imm ? imm_ext : rs2_val;
    op.rd     <= instr.r.rd;
  end

endmodule

//--- design/execute_stage.sv
// ============================================================
// execute stage, 64-bit ALU plus the write-back register
// current and registered results both feed decode forwarding
// ============================================================
module execute_stage
  import rv_alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  operand_if.dst            op,
  output logic              o_ex_valid,
  output logic [REG_AW-1:0] o_ex_rd,
  output logic [XLEN-1:0]   o_ex_data,
  output logic              o_wb_valid,
  output logic [REG_AW-1:0] o_wb_rd,
  output logic [XLEN-1:0]   o_wb_data
);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_res;

  assign shamt = op.op_b[SHAMT_W-1:0];

  always_comb begin
    unique case (op.alu_op)
      ALU_ADD:  alu_res = op.op_a + op.op_b;
      ALU_SUB:  alu_res = op.op_a - op.op_b;
      ALU_SLL:  alu_res = op.op_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op.op_a) < $signed(op.op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op.op_a < op.op_b};
      ALU_XOR:  alu_res = op.op_a ^ op.op_b;
      ALU_SRL:  alu_res = op.op_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op.op_a) >>> shamt);
      ALU_OR:   alu_res = op.op_a | op.op_b;
      ALU_AND:  alu_res = op.op_a & op.op_b;
      default:  alu_res = '0;
    endcase
  end

  // same-cycle result for the next instruction in decode
  assign o_ex_valid = op.valid;
  assign o_ex_rd    = op.rd;
  assign o_ex_data  = alu_res;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= op.valid;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_rd   <= op.rd;
    o_wb_data <= alu_res;
  end

endmodule

//--- design/alu_core_top.sv
// ============================================================
// top of the RV64I ALU core, instruction strobe in and
// write-back strobe out, two cycles apart
// ============================================================
module alu_core_top
  import rv_alu_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_instr_valid,
  input  logic [INSTR_W-1:0] i_instr,
  output logic               o_wb_valid,
  output logic [REG_AW-1:0]  o_wb_rd,
  output logic [XLEN-1:0]    o_wb_data
);

  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              ex_valid;
  logic [REG_AW-1:0] ex_rd;
  logic [XLEN-1:0]   ex_data;

  operand_if u_op_bus ();

  decode_stage u_decode_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .i_ex_valid    (ex_valid),
    .i_ex_rd       (ex_rd),
    .i_ex_data     (ex_data),
    .i_wb_valid    (o_wb_valid),
    .i_wb_rd       (o_wb_rd),
    .i_wb_data     (o_wb_data),
    .op            (u_op_bus.src)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .op         (u_op_bus.dst),
    .o_ex_valid (ex_valid),
    .o_ex_rd    (ex_rd),
    .o_ex_data  (ex_data),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data)
  );

  // write port is the write-back stage
  reg_file u_reg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr_valid (o_wb_valid),
    .i_wr_rd    (o_wb_rd),
    .i_wr_data  (o_wb_data)
  );

endmodule

//--- verif/alu_core_chk.sv
// ============================================================
// write-back port assertions, bound into the ALU core top
// ============================================================
module alu_core_chk
  import rv_alu_pkg::*;
(
  input logic               clk,
  input logic               rst_n,
  input logic               i_instr_valid,
  input logic [INSTR_W-1:0] i_instr,
  input logic               o_wb_valid,
  input logic [REG_AW-1:0]  o_wb_rd
);

  timeunit 1ns;
  timeprecision 1ps;

  instr_u word;
  logic   accepted;

  assign word = i_instr;
  // instruction that must come out as a write-back
  assign accepted = i_instr_valid && (word.r.opcode == OPC_OP || word.i.opcode == OPC_OP_IMM)
                    && word.r.rd != '0;

  a_wb_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(o_wb_valid))
    else $error("write-back valid is unknown");

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    o_wb_valid |-> o_wb_rd != '0)
    else $error("write-back targets x0");

  a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
    o_wb_valid == $past(accepted, 2))
    else $error("write-back valid does not follow the accepted input by two cycles");

endmodule

bind alu_core_top alu_core_chk i_alu_core_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .i_instr_valid (i_instr_valid),
  .i_instr       (i_instr),
  .o_wb_valid    (o_wb_valid),
  .o_wb_rd       (o_wb_rd)
);

//--- verif/alu_core_tb.sv
// ============================================================
// testbench for the RV64I ALU core, a directed table first,
// then random instructions checked against a register model
// ============================================================
module alu_core_tb
  import rv_alu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          RANDOM_COUNT = 300;
  localparam int          DRAIN_LIMIT  = 20;
  localparam logic [31:0] SEED         = 32'h09fa95b0;

  typedef struct {
    string           name;
    int              gap;
    logic            wb;
    logic [31:0]     instr;
    logic [XLEN-1:0] exp;
  } entry_t;

  typedef struct {
    string             name;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
    int                edge_no;
  } expect_t;

  logic               clk;
  logic               rst_n;
  logic               i_instr_valid;
  logic [INSTR_W-1:0] i_instr;
  logic               o_wb_valid;
  logic [REG_AW-1:0]  o_wb_rd;
  logic [XLEN-1:0]    o_wb_data;

  entry_t          tbl[$];
  expect_t         exp_q[$];
  logic [XLEN-1:0] model_regs [0:31];
  logic [31:0]     rng_state;
  int              edge_no;
  int              rd_errors;
  int              data_errors;
  int              other_errors;

  alu_core_top i_alu_core_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_wb_valid    (o_wb_valid),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // number of the last rising edge
  initial edge_no = 0;
  always @(posedge clk) edge_no <= edge_no + 1;

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_supported(logic [31:0] w);
    return (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) && w[11:7] != 5'd0;
  endfunction

  // architectural result from the current model registers
  function automatic logic [XLEN-1:0] model_result(logic [31:0] w);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [5:0]      sh;
    logic            imm_op;
    imm_op = (w[6:0] == OPC_OP_IMM);
    a = model_regs[w[19:15]];
    b = imm_op ? {{(XLEN-12){w[31]}}, w[31:20]} : model_regs[w[24:20]];
    sh = b[5:0];
    case (w[14:12])
      F3_ADD:  return (!imm_op && w[30]) ? a - b : a + b;
      F3_SLL:  return a << sh;
      F3_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      F3_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      F3_XOR:  return a ^ b;
      F3_SR:   return w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // low bits pick the kind, 1 in 8 words is an unsupported LUI
  function automatic logic [31:0] random_word(logic [31:0] r);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3 = r[20:18];
    if (r[2:0] < 3'd4) begin
      return enc_r((r[21] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : 7'd0,
                   r[17:13], r[12:8], f3, r[7:3]);
    end else if (r[2:0] < 3'd7) begin
      if (f3 == F3_SLL || f3 == F3_SR) begin
        imm = {(r[21] && f3 == F3_SR) ? 6'b010000 : 6'b000000, r[27:22]};
      end else begin
        imm = r[31:20];
      end
      return enc_i(imm, r[12:8], f3, r[7:3]);
    end
    return {r[31:7], 7'b0110111};
  endfunction

  task automatic add_entry(string name, int gap, logic wb, logic [31:0] w,
                           logic [XLEN-1:0] exp);
    entry_t e;
    e.name  = name;
    e.gap   = gap;
    e.wb    = wb;
    e.instr = w;
    e.exp   = exp;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    add_entry("addi_neg", 0, 1'b1, enc_i(12'hFFB, 5'd0, F3_ADD, 5'd1), 64'hFFFF_FFFF_FFFF_FFFB);
    add_entry("addi_pos", 0, 1'b1, enc_i(12'h7FF, 5'd0, F3_ADD, 5'd2), 64'h7FF);
    add_entry("andi_wb_fwd", 0, 1'b1, enc_i(12'h0F0, 5'd1, F3_AND, 5'd3), 64'hF0);
    add_entry("ori_ex_fwd", 0, 1'b1, enc_i(12'hF00, 5'd3, F3_OR, 5'd4), 64'hFFFF_FFFF_FFFF_FFF0);
    add_entry("xori_regfile", 0, 1'b1, enc_i(12'h555, 5'd2, F3_XOR, 5'd5), 64'h2AA);
    add_entry("slti", 0, 1'b1, enc_i(12'hFFC, 5'd1, F3_SLT, 5'd6), 64'h1);
    add_entry("sltiu", 0, 1'b1, enc_i(12'hFFC, 5'd1, F3_SLTU, 5'd7), 64'h1);
    add_entry("slli_40", 0, 1'b1, enc_i(12'h028, 5'd2, F3_SLL, 5'd8), 64'h0007_FF00_0000_0000);
    add_entry("srli_60", 0, 1'b1, enc_i(12'h03C, 5'd1, F3_SR, 5'd9), 64'hF);
    add_entry("srai_1", 0, 1'b1, enc_i(12'h401, 5'd1, F3_SR, 5'd10), 64'hFFFF_FFFF_FFFF_FFFD);
    add_entry("add", 0, 1'b1, enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd11), 64'h7FA);
    add_entry("sub_x0", 0, 1'b1, enc_r(F7_ALT, 5'd2, 5'd0, F3_ADD, 5'd12), 64'hFFFF_FFFF_FFFF_F801);
    add_entry("addi_shamt", 0, 1'b1, enc_i(12'h024, 5'd0, F3_ADD, 5'd13), 64'h24);
    add_entry("sll_36", 0, 1'b1, enc_r(7'd0, 5'd13, 5'd2, F3_SLL, 5'd14), 64'h0000_7FF0_0000_0000);
    add_entry("srl_36", 0, 1'b1, enc_r(7'd0, 5'd13, 5'd1, F3_SR, 5'd15), 64'h0FFF_FFFF);
    add_entry("sra_neg", 0, 1'b1, enc_r(F7_ALT, 5'd13, 5'd12, F3_SR, 5'd16), '1);
    add_entry("slt", 0, 1'b1, enc_r(7'd0, 5'd2, 5'd1, F3_SLT, 5'd17), 64'h1);
    add_entry("sltu", 0, 1'b1, enc_r(7'd0, 5'd2, 5'd1, F3_SLTU, 5'd18), 64'h0);
    add_entry("xor", 0, 1'b1, enc_r(7'd0, 5'd2, 5'd1, F3_XOR, 5'd19), 64'hFFFF_FFFF_FFFF_F804);
    add_entry("or", 0, 1'b1, enc_r(7'd0, 5'd5, 5'd3, F3_OR, 5'd20), 64'h2FA);
    add_entry("and", 0, 1'b1, enc_r(7'd0, 5'd2, 5'd1, F3_AND, 5'd21), 64'h7FB);
    add_entry("chain_base", 0, 1'b1, enc_i(12'h064, 5'd0, F3_ADD, 5'd22), 64'h64);
    add_entry("chain_double", 0, 1'b1, enc_r(7'd0, 5'd22, 5'd22, F3_ADD, 5'd22), 64'hC8);
    add_entry("chain_inc", 0, 1'b1, enc_i(12'h001, 5'd22, F3_ADD, 5'd22), 64'hC9);
    add_entry("gap_sub", 1, 1'b1, enc_r(F7_ALT, 5'd21, 5'd22, F3_ADD, 5'd23),
              64'hFFFF_FFFF_FFFF_F8CE);
    add_entry("gap_or", 2, 1'b1, enc_r(7'd0, 5'd0, 5'd23, F3_OR, 5'd24),
              64'hFFFF_FFFF_FFFF_F8CE);
    add_entry("rd_zero", 0, 1'b0, enc_i(12'h005, 5'd1, F3_ADD, 5'd0), '0);
    add_entry("x0_reads_zero", 0, 1'b1, enc_r(7'd0, 5'd0, 5'd0, F3_OR, 5'd25), 64'h0);
    add_entry("lui_dropped", 0, 1'b0, 32'h1234_50B7, '0);
    add_entry("x1_kept", 0, 1'b1, enc_r(7'd0, 5'd0, 5'd1, F3_ADD, 5'd26),
              64'hFFFF_FFFF_FFFF_FFFB);
  endtask

  task automatic issue(string name, logic [31:0] w, logic want_wb, logic use_exp,
                       logic [XLEN-1:0] exp_val);
    expect_t e;
    @(posedge clk);
    i_instr_valid <= 1'b1;
    i_instr       <= w;
    if (want_wb) begin
      e.name    = name;
      e.rd      = w[11:7];
      e.data    = use_exp ? exp_val : model_result(w);
      e.edge_no = edge_no + 1;
      model_regs[w[11:7]] = e.data;
      exp_q.push_back(e);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    i_instr_valid <= 1'b0;
    // supported word, must be ignored while valid is low
    i_instr <= enc_i(12'h0FF, 5'd1, F3_ADD, 5'd1);
  endtask

  task automatic check_rd(string name, logic [REG_AW-1:0] exp, logic [REG_AW-1:0] act);
    if (act !== exp) begin
      $display("Error rd in %s: expected x%0d, actual x%0d", name, exp, act);
      rd_errors++;
    end
  endtask

  task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("Error data in %s: expected %h, actual %h", name, exp, act);
      data_errors++;
    end
  endtask

  always @(negedge clk) begin : wb_monitor
    expect_t e;
    if (rst_n && $isunknown(o_wb_valid)) begin
      $display("write-back valid is unknown at edge %0d", edge_no);
      other_errors++;
    end else if (rst_n && o_wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected write-back to x%0d with nothing outstanding", o_wb_rd);
        other_errors++;
      end else begin
        e = exp_q.pop_front();
        check_rd(e.name, e.rd, o_wb_rd);
        check_data(e.name, e.data, o_wb_data);
        if (edge_no != e.edge_no + 2) begin
          $display("write-back of %s came %0d cycles after issue instead of 2",
                   e.name, edge_no - e.edge_no);
          other_errors++;
        end
      end
    end
  end

  initial begin
    int          waited;
    logic [31:0] w;
    rst_n         = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    rd_errors     = 0;
    data_errors   = 0;
    other_errors  = 0;
    model_regs    = '{default: '0};
    rng_state     = SEED;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    foreach (tbl[k]) begin
      repeat (tbl[k].gap) idle_cycle();
      issue(tbl[k].name, tbl[k].instr, tbl[k].wb, 1'b1, tbl[k].exp);
    end

    for (int n = 0; n < RANDOM_COUNT; n++) begin
      rng_state = xorshift32(rng_state);
      w = random_word(rng_state);
      issue($sformatf("random_%0d", n), w, is_supported(w), 1'b0, '0);
      if (rng_state[31:30] == 2'b11) begin
        idle_cycle();
      end
    end
    idle_cycle();

    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout, %0d write-backs never arrived", exp_q.size());
      other_errors++;
    end

    $display("errors: rd %0d, data %0d, other %0d", rd_errors, data_errors, other_errors);
    if (rd_errors + data_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/rv_alu_pkg.sv
design/operand_if.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/alu_core_top.sv
verif/alu_core_chk.sv
verif/alu_core_tb.sv

//--- Makefile
# Verilator build and run of the RV64I ALU core testbench

VERILATOR ?= verilator
TOP       ?= alu_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
